// ==== source/core_pkg.sv ====
package core_pkg;

    localparam int RW = 16;
    localparam int I_SIZE = 32;
    localparam int REGNO = 8;
    localparam int REGNO_LOG = 3;

    // Field positions in the instruction word
    localparam int OP_LSB = 12;
    localparam int RD_LSB = 9;
    localparam int RS_LSB = 6;
    localparam int IMM_LSB = 16;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SHL,
        OP_SHR,
        OP_LDI,
        OP_ADDI,
        OP_LD,
        OP_ST,
        OP_JMP,
        OP_JZ,
        OP_JNZ
    } op_e;

    // Register ops map onto the first seven entries in op_e order
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR,
        ALU_PASS_R
    } alu_e;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_ALWAYS,
        JMP_ZERO,
        JMP_NZERO
    } jump_e;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_WAIT,
        FS_HOLD
    } fetch_state_e;

    typedef enum logic [1:0] {
        MW_IDLE,
        MW_MEM,
        MW_WB
    } mw_state_e;

endpackage

// ==== source/fetch.sv ====
`timescale 1ns/1ps

module fetch (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_disable,
    input  logic [core_pkg::I_SIZE-1:0] i_req_data,
    input  logic                        i_req_data_valid,
    input  logic                        i_next_ready,
    input  logic                        i_flush,
    input  logic [core_pkg::RW-1:0]     i_exec_pc,
    output logic [core_pkg::RW-1:0]     o_req_addr,
    output logic                        o_req_ppl_submit,
    output logic                        o_submit,
    output logic [core_pkg::I_SIZE-1:0] o_instr,
    output logic [core_pkg::RW-1:0]     o_pc
);
    import core_pkg::*;

    fetch_state_e state;
    logic [RW-1:0] pc;      // Next word to request
    logic stale;            // Outstanding response is from a flushed path
    logic issue;

    assign o_submit = (state == FS_HOLD);

    // Request from idle, or right behind the instruction being handed on
    assign issue = !i_disable && !i_flush &&
                   (state == FS_IDLE || (state == FS_HOLD && i_next_ready));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= FS_IDLE;
            o_req_ppl_submit <= 1'b0;
            stale <= 1'b0;
            pc <= '0;
        end else begin
            o_req_ppl_submit <= issue;
            if (i_flush)
                pc <= i_exec_pc;
            else if (issue)
                pc <= pc + 1'b1;

            case (state)
                FS_IDLE: begin
                    if (issue)
                        state <= FS_WAIT;
                end
                FS_WAIT: begin
                    if (i_req_data_valid) begin
                        stale <= 1'b0;
                        state <= (stale || i_flush) ? FS_IDLE : FS_HOLD;
                    end else if (i_flush) begin
                        stale <= 1'b1;  // Drop it when it turns up
                    end
                end
                FS_HOLD: begin
                    if (i_flush)
                        state <= FS_IDLE;
                    else if (i_next_ready)
                        state <= issue ? FS_WAIT : FS_IDLE;
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue)
            o_req_addr <= pc;
        if (state == FS_WAIT && i_req_data_valid) begin
            o_instr <= i_req_data;
            o_pc <= o_req_addr;     // Address is held until the response
        end
    end

endmodule

// ==== source/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_submit,
    input  logic [core_pkg::I_SIZE-1:0]    i_instr,
    input  logic [core_pkg::RW-1:0]        i_pc,
    input  logic                           i_next_ready,
    input  logic                           i_flush,
    output logic                           o_ready,
    output logic                           o_submit,
    output logic [core_pkg::RW-1:0]        o_pc,
    output logic [core_pkg::RW-1:0]        o_imm,
    output core_pkg::alu_e                 oc_alu_mode,
    output logic                           oc_r_bus_imm,
    output logic [core_pkg::REGNO_LOG-1:0] oc_l_reg_sel,
    output logic [core_pkg::REGNO_LOG-1:0] oc_r_reg_sel,
    output logic                           oc_reg_we,
    output logic                           oc_flags_ie,
    output logic                           oc_mem_access,
    output logic                           oc_mem_we,
    output core_pkg::jump_e                oc_jump_cond_code,
    output logic [1:0]                     oc_used_operands
);
    import core_pkg::*;

    logic full;
    logic [I_SIZE-1:0] instr;
    logic accept;
    op_e op;

    assign o_ready = !full || i_next_ready;
    assign o_submit = full;
    assign accept = i_submit && o_ready && !i_flush;

    assign op = op_e'(instr[OP_LSB +: 4]);
    assign oc_l_reg_sel = instr[RD_LSB +: REGNO_LOG];
    assign oc_r_reg_sel = instr[RS_LSB +: REGNO_LOG];
    assign o_imm = instr[IMM_LSB +: RW];

    always_ff @(posedge i_clk) begin
        if (i_rst)
            full <= 1'b0;
        else if (i_flush)
            full <= 1'b0;
        else if (accept)
            full <= 1'b1;
        else if (i_next_ready)
            full <= 1'b0;
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            instr <= i_instr;
            o_pc <= i_pc;
        end
    end

    // Bit 0 of the used mask is rd, bit 1 is rs
    always_comb begin
        oc_alu_mode = ALU_PASS_R;
        oc_r_bus_imm = 1'b0;
        oc_reg_we = 1'b0;
        oc_flags_ie = 1'b0;
        oc_mem_access = 1'b0;
        oc_mem_we = 1'b0;
        oc_jump_cond_code = JMP_NONE;
        oc_used_operands = 2'b00;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR: begin
                oc_alu_mode = alu_e'(3'(op - 4'd1));   // One below the opcode
                oc_reg_we = 1'b1;
                oc_flags_ie = 1'b1;
                oc_used_operands = 2'b11;
            end
            OP_LDI: begin
                oc_r_bus_imm = 1'b1;
                oc_reg_we = 1'b1;
                oc_flags_ie = 1'b1;
            end
            OP_ADDI: begin
                oc_alu_mode = ALU_ADD;
                oc_r_bus_imm = 1'b1;
                oc_reg_we = 1'b1;
                oc_flags_ie = 1'b1;
                oc_used_operands = 2'b10;
            end
            OP_LD, OP_ST: begin
                oc_alu_mode = ALU_ADD;  // Address is rs + imm
                oc_r_bus_imm = 1'b1;
                oc_mem_access = 1'b1;
                oc_mem_we = (op == OP_ST);
                oc_reg_we = (op == OP_LD);
                oc_used_operands = (op == OP_ST) ? 2'b11 : 2'b10;
            end
            OP_JMP: oc_jump_cond_code = JMP_ALWAYS;
            OP_JZ: oc_jump_cond_code = JMP_ZERO;
            OP_JNZ: oc_jump_cond_code = JMP_NZERO;
            default: ;
        endcase
    end

endmodule

// ==== source/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_submit,
    input  core_pkg::alu_e                 c_alu_mode,
    input  logic                           c_r_bus_imm,
    input  logic [core_pkg::REGNO_LOG-1:0] c_l_reg_sel,
    input  logic [core_pkg::REGNO_LOG-1:0] c_r_reg_sel,
    input  logic                           c_reg_we,
    input  logic                           c_flags_ie,
    input  logic                           c_mem_access,
    input  logic                           c_mem_we,
    input  core_pkg::jump_e                c_jump_cond_code,
    input  logic [1:0]                     c_used_operands,
    input  logic [core_pkg::RW-1:0]        i_pc,
    input  logic [core_pkg::RW-1:0]        i_imm,
    input  logic                           i_next_ready,
    input  logic                           i_reg_we,
    input  logic [core_pkg::REGNO_LOG-1:0] i_reg_sel,
    input  logic [core_pkg::RW-1:0]        i_reg_data,
    output logic                           o_ready,
    output logic                           o_submit,
    output logic [core_pkg::RW-1:0]        o_data,
    output logic [core_pkg::RW-1:0]        o_addr,
    output logic                           o_reg_we,
    output logic [core_pkg::REGNO_LOG-1:0] o_reg_sel,
    output logic                           o_mem_access,
    output logic                           o_mem_we,
    output logic                           o_pc_update,
    output logic [core_pkg::RW-1:0]        o_exec_pc,
    output logic                           o_flush,
    output logic [core_pkg::RW-1:0]        dbg_r0,
    output logic [core_pkg::RW-1:0]        dbg_pc
);
    import core_pkg::*;

    logic [RW-1:0] regs [REGNO];
    logic [REGNO-1:0] pending;  // Writes still on their way back from memwb
    logic zf;
    logic hazard;
    logic issue;
    logic taken;
    logic [RW-1:0] a_val;
    logic [RW-1:0] b_val;
    logic [RW-1:0] result;

    assign dbg_r0 = regs[0];

    assign hazard = ((c_used_operands[0] || c_reg_we) && pending[c_l_reg_sel]) ||
                    (c_used_operands[1] && pending[c_r_reg_sel]);

    // One item in flight to memwb, and nothing while the flush is out
    assign o_ready = i_next_ready && !o_submit && !o_flush && !hazard;
    assign issue = i_submit && o_ready;

    // Immediate forms take rs on the left
    assign a_val = c_r_bus_imm ? regs[c_r_reg_sel] : regs[c_l_reg_sel];
    assign b_val = c_r_bus_imm ? i_imm : regs[c_r_reg_sel];

    always_comb begin
        case (c_alu_mode)
            ALU_ADD: result = a_val + b_val;
            ALU_SUB: result = a_val - b_val;
            ALU_AND: result = a_val & b_val;
            ALU_OR: result = a_val | b_val;
            ALU_XOR: result = a_val ^ b_val;
            ALU_SHL: result = a_val << b_val[3:0];
            ALU_SHR: result = a_val >> b_val[3:0];
            default: result = b_val;
        endcase
    end

    always_comb begin
        case (c_jump_cond_code)
            JMP_ALWAYS: taken = 1'b1;
            JMP_ZERO: taken = zf;
            JMP_NZERO: taken = !zf;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reg_we)
            regs[i_reg_sel] <= i_reg_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending <= '0;
            zf <= 1'b0;
            o_submit <= 1'b0;
            o_reg_we <= 1'b0;
            o_mem_access <= 1'b0;
            o_mem_we <= 1'b0;
            o_flush <= 1'b0;
            o_pc_update <= 1'b0;
            dbg_pc <= '0;
        end else begin
            o_submit <= 1'b0;
            o_flush <= 1'b0;
            o_pc_update <= 1'b0;
            if (i_reg_we)
                pending[i_reg_sel] <= 1'b0;
            if (issue) begin
                dbg_pc <= i_pc;
                if (c_flags_ie)
                    zf <= (result == '0);
                if (taken) begin
                    o_flush <= 1'b1;
                    o_pc_update <= 1'b1;
                end else if (c_reg_we || c_mem_access) begin   // NOPs stop here
                    o_submit <= 1'b1;
                    o_reg_we <= c_reg_we;
                    o_mem_access <= c_mem_access;
                    o_mem_we <= c_mem_we;
                    if (c_reg_we)
                        pending[c_l_reg_sel] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_data <= c_mem_we ? regs[c_l_reg_sel] : result;  // Store value or result
            o_addr <= result;
            o_reg_sel <= c_l_reg_sel;
            o_exec_pc <= i_imm;
        end
    end

endmodule

// ==== source/memwb.sv ====
`timescale 1ns/1ps

module memwb (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_submit,
    input  logic [core_pkg::RW-1:0]        i_data,
    input  logic [core_pkg::RW-1:0]        i_addr,
    input  logic                           i_reg_we,
    input  logic [core_pkg::REGNO_LOG-1:0] i_reg_sel,
    input  logic                           i_mem_access,
    input  logic                           i_mem_we,
    input  logic [core_pkg::RW-1:0]        i_mem_data,
    input  logic                           i_mem_ack,
    output logic                           o_ready,
    output logic                           o_reg_we,
    output logic [core_pkg::REGNO_LOG-1:0] o_reg_sel,
    output logic [core_pkg::RW-1:0]        o_reg_data,
    output logic                           o_mem_req,
    output logic [core_pkg::RW-1:0]        o_mem_addr,
    output logic [core_pkg::RW-1:0]        o_mem_data,
    output logic                           o_mem_we
);
    import core_pkg::*;

    mw_state_e state;
    logic wb_we;    // Item returns a register write

    assign o_ready = (state == MW_IDLE);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= MW_IDLE;
            wb_we <= 1'b0;
            o_reg_we <= 1'b0;
            o_mem_req <= 1'b0;
            o_mem_we <= 1'b0;
        end else begin
            o_reg_we <= 1'b0;
            case (state)
                MW_IDLE: begin
                    if (i_submit) begin
                        wb_we <= i_reg_we;
                        o_mem_we <= i_mem_we;
                        if (i_mem_access) begin
                            o_mem_req <= 1'b1;
                            state <= MW_MEM;
                        end else begin
                            o_reg_we <= i_reg_we;
                            state <= MW_WB;
                        end
                    end
                end
                MW_MEM: begin
                    if (i_mem_ack) begin
                        o_mem_req <= 1'b0;
                        o_reg_we <= wb_we;  // Loads only
                        state <= wb_we ? MW_WB : MW_IDLE;
                    end
                end
                default: state <= MW_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == MW_IDLE && i_submit) begin
            o_mem_addr <= i_addr;
            o_mem_data <= i_data;
            o_reg_sel <= i_reg_sel;
            o_reg_data <= i_data;
        end else if (state == MW_MEM && i_mem_ack) begin
            o_reg_data <= i_mem_data;
        end
    end

endmodule

// ==== source/core.sv ====
`timescale 1ns/1ps

module core (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_disable,
    output logic [core_pkg::RW-1:0]     o_req_addr,
    output logic                        o_req_active,
    output logic                        o_req_ppl_submit,
    input  logic [core_pkg::I_SIZE-1:0] i_req_data,
    input  logic                        i_req_data_valid,
    output logic [core_pkg::RW-1:0]     o_mem_addr,
    output logic [core_pkg::RW-1:0]     o_mem_data,
    input  logic [core_pkg::RW-1:0]     i_mem_data,
    output logic                        o_mem_req,
    output logic                        o_mem_we,
    input  logic                        i_mem_ack,
    output logic [core_pkg::RW-1:0]     dbg_r0,
    output logic [core_pkg::RW-1:0]     dbg_pc
);
    import core_pkg::*;

    logic fd_submit, fd_ready;
    logic [I_SIZE-1:0] fd_instr;
    logic [RW-1:0] fd_pc;
    logic pc_update, flush;
    logic [RW-1:0] exec_pc;

    logic de_submit, de_ready;
    logic [RW-1:0] de_pc, de_imm;
    alu_e dec_alu_mode;
    jump_e dec_jump_cond_code;
    logic dec_r_bus_imm, dec_reg_we, dec_flags_ie, dec_mem_access, dec_mem_we;
    logic [REGNO_LOG-1:0] dec_l_reg_sel, dec_r_reg_sel;
    logic [1:0] dec_used_operands;

    logic ew_submit, ew_ready, ew_reg_we, ew_mem_access, ew_mem_we;
    logic [RW-1:0] ew_data, ew_addr;
    logic [REGNO_LOG-1:0] ew_reg_sel;
    logic we_reg_we;
    logic [REGNO_LOG-1:0] we_reg_sel;
    logic [RW-1:0] we_reg_data;

    assign o_req_active = ~i_disable;

    // Stage 0 takes its PC load from the jump
    fetch fetch (
        .i_clk(i_clk), .i_rst(i_rst), .i_disable(i_disable), .i_req_data(i_req_data),
        .i_req_data_valid(i_req_data_valid), .i_next_ready(fd_ready), .i_flush(pc_update),
        .i_exec_pc(exec_pc), .o_req_addr(o_req_addr), .o_req_ppl_submit(o_req_ppl_submit),
        .o_submit(fd_submit), .o_instr(fd_instr), .o_pc(fd_pc));

    // Stage 1
    decode decode (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(fd_submit), .i_instr(fd_instr), .i_pc(fd_pc),
        .i_next_ready(de_ready), .i_flush(flush), .o_ready(fd_ready), .o_submit(de_submit),
        .o_pc(de_pc), .o_imm(de_imm), .oc_alu_mode(dec_alu_mode), .oc_r_bus_imm(dec_r_bus_imm),
        .oc_l_reg_sel(dec_l_reg_sel), .oc_r_reg_sel(dec_r_reg_sel), .oc_reg_we(dec_reg_we),
        .oc_flags_ie(dec_flags_ie), .oc_mem_access(dec_mem_access), .oc_mem_we(dec_mem_we),
        .oc_jump_cond_code(dec_jump_cond_code), .oc_used_operands(dec_used_operands));

    // Stage 2
    execute execute (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(de_submit), .c_alu_mode(dec_alu_mode),
        .c_r_bus_imm(dec_r_bus_imm), .c_l_reg_sel(dec_l_reg_sel), .c_r_reg_sel(dec_r_reg_sel),
        .c_reg_we(dec_reg_we), .c_flags_ie(dec_flags_ie), .c_mem_access(dec_mem_access),
        .c_mem_we(dec_mem_we), .c_jump_cond_code(dec_jump_cond_code),
        .c_used_operands(dec_used_operands), .i_pc(de_pc), .i_imm(de_imm),
        .i_next_ready(ew_ready), .i_reg_we(we_reg_we), .i_reg_sel(we_reg_sel),
        .i_reg_data(we_reg_data), .o_ready(de_ready), .o_submit(ew_submit), .o_data(ew_data),
        .o_addr(ew_addr), .o_reg_we(ew_reg_we), .o_reg_sel(ew_reg_sel),
        .o_mem_access(ew_mem_access), .o_mem_we(ew_mem_we), .o_pc_update(pc_update),
        .o_exec_pc(exec_pc), .o_flush(flush), .dbg_r0(dbg_r0), .dbg_pc(dbg_pc));

    // Stage 3
    memwb memwb (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(ew_submit), .i_data(ew_data), .i_addr(ew_addr),
        .i_reg_we(ew_reg_we), .i_reg_sel(ew_reg_sel), .i_mem_access(ew_mem_access),
        .i_mem_we(ew_mem_we), .i_mem_data(i_mem_data), .i_mem_ack(i_mem_ack),
        .o_ready(ew_ready), .o_reg_we(we_reg_we), .o_reg_sel(we_reg_sel),
        .o_reg_data(we_reg_data), .o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr),
        .o_mem_data(o_mem_data), .o_mem_we(o_mem_we));

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    input  logic i_restart,
    output logic o_clk,
    output logic o_rst
);
    int rst_cycles = 4;

    initial begin
        o_clk = 1'b0;
        o_rst = 1'b1;
        forever #10 o_clk = ~o_clk;
    end

    // Reset covers four rising edges, again after every restart request
    always @(posedge o_clk) begin
        if (i_restart)
            rst_cycles = 4;
        else if (rst_cycles != 0)
            rst_cycles = rst_cycles - 1;
        #1;
        o_rst = (rst_cycles != 0);
    end

endmodule

// ==== dv/core_checker.sv ====
`timescale 1ns/1ps

module core_checker (
    input logic                    i_clk,
    input logic                    i_rst,
    input logic                    i_disable,
    input logic                    o_req_ppl_submit,
    input logic                    o_mem_req,
    input logic [core_pkg::RW-1:0] o_mem_addr,
    input logic [core_pkg::RW-1:0] o_mem_data,
    input logic                    o_mem_we,
    input logic                    i_mem_ack
);

    // Data request held with its payload until the ack
    mem_req_held: assert property (@(posedge i_clk) disable iff (i_rst)
        o_mem_req && !i_mem_ack |=> o_mem_req && $stable(o_mem_addr) &&
            $stable(o_mem_data) && $stable(o_mem_we))
        else $error("data request dropped or changed before its ack");

    // Pulse is registered, so it is checked one edge later
    no_fetch_disabled: assert property (@(posedge i_clk) disable iff (i_rst)
        i_disable |=> !o_req_ppl_submit)
        else $error("instruction request issued while disabled");

    quiet_in_reset: assert property (@(posedge i_clk)
        i_rst |=> !o_mem_req && !o_req_ppl_submit)
        else $error("request active during reset");

endmodule

bind core core_checker checker_i (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_disable(i_disable),
    .o_req_ppl_submit(o_req_ppl_submit),
    .o_mem_req(o_mem_req),
    .o_mem_addr(o_mem_addr),
    .o_mem_data(o_mem_data),
    .o_mem_we(o_mem_we),
    .i_mem_ack(i_mem_ack)
);

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam int NUM_PROGS = 8;
    localparam int PROG_LEN = 64;
    localparam int SELF_PC = PROG_LEN - 1;
    localparam int FINAL_ST = SELF_PC - REGNO;  // First of the closing stores
    localparam int CYCLES_PER_INSTR = 20;
    localparam int TIMEOUT_CYCLES = NUM_PROGS * PROG_LEN * CYCLES_PER_INSTR;

    logic clk;
    logic rst;
    logic restart = 1'b0;
    logic req_disable = 1'b0;
    logic [RW-1:0] req_addr;
    logic req_active;
    logic req_submit;
    logic [I_SIZE-1:0] req_data = '0;
    logic req_valid = 1'b0;
    logic [RW-1:0] mem_addr;
    logic [RW-1:0] mem_wdata;
    logic [RW-1:0] mem_rdata = '0;
    logic mem_req;
    logic mem_we;
    logic mem_ack = 1'b0;
    logic [RW-1:0] dbg_r0;
    logic [RW-1:0] dbg_pc;

    logic [I_SIZE-1:0] imem [PROG_LEN];
    logic [RW-1:0] dmem [256];
    logic [RW-1:0] model_mem [256];
    logic [RW-1:0] exp_addr [$];
    logic [RW-1:0] exp_data [$];
    logic [RW-1:0] model_r0;

    int seed = 32'h7c86;
    int fetch_seed = 32'h7c86 + 1;
    int data_seed = 32'h7c86 + 2;
    int dis_seed = 32'h7c86 + 3;
    int prog = 0;
    int errors = 0;
    int cycles = 0;

    logic f_busy;
    logic f_fire;
    int f_wait;
    logic [RW-1:0] f_addr;
    logic d_busy;
    logic d_ack;
    int d_wait;
    logic dis_seen = 1'b0;
    int dis_hold;
    int dis_gap;

    tb_clock clock_i (.i_restart(restart), .o_clk(clk), .o_rst(rst));

    core dut_i (
        .i_clk(clk), .i_rst(rst), .i_disable(req_disable), .o_req_addr(req_addr),
        .o_req_active(req_active), .o_req_ppl_submit(req_submit), .i_req_data(req_data),
        .i_req_data_valid(req_valid), .o_mem_addr(mem_addr), .o_mem_data(mem_wdata),
        .i_mem_data(mem_rdata), .o_mem_req(mem_req), .o_mem_we(mem_we), .i_mem_ack(mem_ack),
        .dbg_r0(dbg_r0), .dbg_pc(dbg_pc));

    task automatic stop_on_error(input string why);
        errors++;
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    function automatic logic [I_SIZE-1:0] encode(op_e op, int rd, int rs, logic [RW-1:0] imm);
        return {imm, op, 3'(rd), 3'(rs), 6'b0};
    endfunction

    function automatic logic [I_SIZE-1:0] random_instr(int idx);
        int pick;
        int rd;
        int rs;
        int target;
        logic [RW-1:0] imm;
        pick = {$random(seed)} % 17;
        rd = {$random(seed)} % REGNO;
        rs = {$random(seed)} % REGNO;
        imm = RW'($random(seed));
        target = idx + 1 + {$random(seed)} % 6;  // Forward only
        if (target > FINAL_ST)
            target = FINAL_ST;
        if (pick < 7) begin
            if ({$random(seed)} % 4 == 0)
                rs = rd;    // SUB or XOR with itself gives zero
            return encode(op_e'(pick + 1), rd, rs, imm);
        end
        case (pick)
            7: return encode(OP_LDI, rd, rs, ({$random(seed)} % 4 == 0) ? '0 : imm);
            8: return encode(OP_ADDI, rd, rs, imm);
            9, 10: return encode(OP_LD, rd, rs, imm);
            11, 12: return encode(OP_ST, rd, rs, imm);
            13: return encode(OP_JMP, 0, 0, RW'(target));
            14: return encode(OP_JZ, 0, 0, RW'(target));
            15: return encode(OP_JNZ, 0, 0, RW'(target));
            default: return encode(OP_NOP, 0, 0, '0);
        endcase
    endfunction

    // Register init, random body, closing stores and the self jump
    task automatic build_program();
        for (int i = 0; i < REGNO; i++)
            imem[i] = encode(OP_LDI, i, 0, RW'($random(seed)));
        for (int i = REGNO; i < FINAL_ST; i++)
            imem[i] = random_instr(i);
        for (int i = 0; i < REGNO; i++)
            imem[FINAL_ST + i] = encode(OP_ST, i, i, RW'($random(seed)));
        imem[SELF_PC] = encode(OP_JMP, 0, 0, RW'(SELF_PC));
    endtask

    task automatic fill_data(input int p);
        for (int a = 0; a < 256; a++) begin
            dmem[a] = {8'(a), ~8'(a)} ^ RW'(p * 16'h1357);
            model_mem[a] = dmem[a];
        end
    endtask

    task automatic run_model();
        logic [RW-1:0] regs [REGNO];
        logic [RW-1:0] res;
        logic [RW-1:0] a;
        logic [RW-1:0] b;
        logic [RW-1:0] imm;
        logic zf;
        op_e op;
        int rd;
        int rs;
        int pc;
        zf = 1'b0;
        pc = 0;
        exp_addr.delete();
        exp_data.delete();
        while (pc < SELF_PC) begin
            op = op_e'(imem[pc][15:12]);
            rd = imem[pc][11:9];
            rs = imem[pc][8:6];
            imm = imem[pc][31:16];
            a = regs[rd];
            b = regs[rs];
            pc++;
            case (op)
                OP_ADD: res = a + b;
                OP_SUB: res = a - b;
                OP_AND: res = a & b;
                OP_OR: res = a | b;
                OP_XOR: res = a ^ b;
                OP_SHL: res = a << b[3:0];
                OP_SHR: res = a >> b[3:0];
                OP_LDI: res = imm;
                default: res = b + imm;     // ADDI, and the load/store address
            endcase
            case (op)
                OP_NOP: ;
                OP_LD: regs[rd] = model_mem[res[7:0]];
                OP_ST: begin
                    model_mem[res[7:0]] = a;
                    exp_addr.push_back(res);
                    exp_data.push_back(a);
                end
                OP_JMP: pc = imm;
                OP_JZ: if (zf) pc = imm;
                OP_JNZ: if (!zf) pc = imm;
                default: begin
                    regs[rd] = res;
                    zf = (res == '0);
                end
            endcase
        end
        model_r0 = regs[0];
    endtask

    task automatic wait_program_done();
        do
            @(negedge clk);
        while (exp_addr.size() != 0 || dbg_pc != RW'(SELF_PC));
    endtask

    // Instruction port answers one request at a time
    always begin
        @(posedge clk);
        f_fire = 1'b0;
        if (rst) begin
            f_busy = 1'b0;
        end else begin
            if (!f_busy && req_submit) begin
                f_busy = 1'b1;
                f_addr = req_addr;
                f_wait = {$random(fetch_seed)} % 4;
            end
            if (f_busy) begin
                if (f_wait == 0) begin
                    f_fire = 1'b1;
                    f_busy = 1'b0;
                end else begin
                    f_wait--;
                end
            end
        end
        #1;
        req_valid = f_fire;
        req_data = (f_fire && f_addr < PROG_LEN) ? imem[f_addr] : '0;   // NOPs past the end
    end

    // Data port access happens on the ack edge
    always begin
        @(posedge clk);
        if (rst) begin
            d_busy = 1'b0;
            d_ack = 1'b0;
        end else if (d_ack) begin
            if (mem_we) begin
                if (exp_addr.size() == 0) begin
                    stop_on_error($sformatf("Store to 0x%h that the program never makes",
                                            mem_addr));
                end else begin
                    check_value("o_mem_addr", mem_addr, exp_addr.pop_front());
                    check_value("o_mem_data", mem_wdata, exp_data.pop_front());
                    dmem[mem_addr[7:0]] = mem_wdata;
                end
            end
            d_busy = 1'b0;
            d_ack = 1'b0;
        end else if (mem_req) begin
            if (!d_busy) begin
                d_busy = 1'b1;
                d_wait = {$random(data_seed)} % 4;
            end
            if (d_wait == 0)
                d_ack = 1'b1;
            else
                d_wait--;
        end
        #1;
        mem_ack = d_ack;
        mem_rdata = (d_ack && !mem_we) ? dmem[mem_addr[7:0]] : '0;
    end

    // Random stretches of i_disable
    always begin
        @(posedge clk);
        if (dis_seen)
            check_value("o_req_ppl_submit", req_submit, 0);
        check_value("o_req_active", req_active, !req_disable);
        dis_seen = req_disable && !rst;
        if (rst) begin
            dis_hold = 0;
            dis_gap = 16 + {$random(dis_seed)} % 48;
        end else if (dis_hold != 0) begin
            dis_hold--;
        end else if (dis_gap != 0) begin
            dis_gap--;
        end else begin
            dis_hold = 4 + {$random(dis_seed)} % 16;
            dis_gap = 32 + {$random(dis_seed)} % 64;
        end
        #1;
        req_disable = (dis_hold != 0);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            stop_on_error($sformatf("Timeout, program %0d did not finish within %0d cycles",
                                    prog, TIMEOUT_CYCLES));
    end

    initial begin
        for (prog = 0; prog < NUM_PROGS; prog++) begin
            if (prog != 0) begin
                @(posedge clk);
                #1;
                restart = 1'b1;
                @(posedge clk);
                #1;
                restart = 1'b0;
                wait (rst);
            end
            build_program();
            fill_data(prog);
            run_model();
            wait (!rst);
            wait_program_done();
            repeat (8) @(posedge clk);  // Room for a stray store to show up
            @(negedge clk);
            check_value("dbg_r0", dbg_r0, model_r0);
            check_value("dbg_pc", dbg_pc, SELF_PC);
        end
        if (errors == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

// ==== files.f ====
source/core_pkg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memwb.sv
source/core.sv
dv/tb_clock.sv
dv/core_checker.sv
dv/core_tb.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - source/core_pkg.sv
  - source/fetch.sv
  - source/decode.sv
  - source/execute.sv
  - source/memwb.sv
  - source/core.sv
  - target: simulation
    files:
      - dv/tb_clock.sv
      - dv/core_checker.sv
      - dv/core_tb.sv
